//--- dv/fetch_tb.sv
/*
 * Instruction-fetch testbench
 * Preloads memory from an LCG, then runs directed fetch, hit, redirect,
 * data-priority, stall and conflict tests against a reference copy
 */

module fetch_tb;

    ////////////////////////////////////////////////////////////////////////////
    // Test constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 5;
    localparam int PRELOAD_LINES   = 512;  // Covers 0x0000..0x0FFF
    localparam int MISS_TIMEOUT    = 40;   // Cycles allowed for one instruction to show up
    localparam int COLD_COUNT      = 12;
    localparam int PRIORITY_CYCLES = 30;
    localparam int RESUME_COUNT    = 6;
    localparam int STALL_CYCLES    = 5;
    localparam int CONFLICT_ROUNDS = 4;
    localparam int MARGIN          = 2;

    // Every sampled instruction or held cycle is bounded by one miss timeout
    localparam int TEST_EVENTS = 2 * COLD_COUNT + 4 + PRIORITY_CYCLES + RESUME_COUNT +
                                 STALL_CYCLES + 2 + 2 * CONFLICT_ROUNDS;
    localparam int WATCHDOG_CYCLES = (2 * RESET_CYCLES + PRELOAD_LINES +
                                      TEST_EVENTS * MISS_TIMEOUT) * MARGIN;

    localparam fetch_pkg::addr_t RESET_PC     = 32'h0000_0040; // Index 8
    localparam fetch_pkg::addr_t ABANDON_PC   = 32'h0000_0280; // Index 16
    localparam fetch_pkg::addr_t TARGET_PC    = 32'h0000_0390; // Index 18
    localparam fetch_pkg::addr_t PRIORITY_PC  = 32'h0000_05a0; // Index 20
    localparam fetch_pkg::addr_t STALL_PC     = 32'h0000_06f0; // Index 30
    localparam fetch_pkg::addr_t CONFLICT_A   = 32'h0000_0100; // Index 0, tag 1
    localparam fetch_pkg::addr_t CONFLICT_B   = 32'h0000_0700; // Index 0, tag 7

    logic             clock;
    logic             reset;
    fetch_pkg::addr_t reset_pc;
    logic             stall;
    logic             redirect;
    fetch_pkg::addr_t redirect_pc;
    logic             dmem_priority;
    logic             load_en;
    fetch_pkg::addr_t load_addr;
    fetch_pkg::line_t load_data;
    fetch_pkg::inst_t inst;
    fetch_pkg::addr_t inst_pc;
    logic             inst_valid;

    fetch_pkg::inst_t ref_words [2 * PRELOAD_LINES]; // Testbench copy of memory by word
    logic [31:0]      lcg_state;

    fetch_top fetch_top_inst (
        .clock         (clock),
        .reset         (reset),
        .reset_pc      (reset_pc),
        .stall         (stall),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .dmem_priority (dmem_priority),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .inst_valid    (inst_valid)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_lcg(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Words sit little-endian in each line, one entry per 4 bytes
    function automatic fetch_pkg::inst_t ref_inst(fetch_pkg::addr_t pc);
        return ref_words[pc[11:2]];
    endfunction

    task automatic stop_on_error(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        stop_on_error($sformatf("[FAIL] time=%0t %s expected %h actual %h",
                                $time, name, expected, actual));
    endtask

    task automatic expect_valid(logic want);
        assert (inst_valid == want)
            else report_mismatch("inst_valid", {31'd0, want}, {31'd0, inst_valid});
    endtask

    task automatic check_inst(fetch_pkg::addr_t exp_pc);
        assert (inst_pc == exp_pc) else report_mismatch("inst_pc", exp_pc, inst_pc);
        assert (inst == ref_inst(exp_pc)) else report_mismatch("inst", ref_inst(exp_pc), inst);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    endtask

    // One line per cycle, two LCG words each
    task automatic preload_memory();
        fetch_pkg::addr_t a;
        fetch_pkg::line_t l;
        a = '0;
        for (int i = 0; i < PRELOAD_LINES; i++) begin
            lcg_state = next_lcg(lcg_state);
            l[31:0]   = lcg_state;
            lcg_state = next_lcg(lcg_state);
            l[63:32]  = lcg_state;
            ref_words[2 * i]     = l[31:0];
            ref_words[2 * i + 1] = l[63:32];
            load_en   = 1'b1;
            load_addr = a;
            load_data = l;
            @(negedge clock);
            a = a + 32'd8;
        end
        load_en = 1'b0;
    endtask

    // Redirect is seen at the next rising edge
    task automatic redirect_to(fetch_pkg::addr_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clock);
        redirect    = 1'b0;
    endtask

    task automatic wait_valid(string what);
        int waited;
        waited = 0;
        while (!inst_valid) begin
            if (waited >= MISS_TIMEOUT) begin
                stop_on_error($sformatf("No instruction within %0d cycles while %s",
                                        MISS_TIMEOUT, what));
            end
            waited++;
            @(negedge clock);
        end
    endtask

    // Sequential stream, pc steps by 4 per delivered instruction
    task automatic collect_stream(fetch_pkg::addr_t start_pc, int count);
        fetch_pkg::addr_t exp_pc;
        exp_pc = start_pc;
        for (int n = 0; n < count; n++) begin
            wait_valid("collecting a sequential stream");
            check_inst(exp_pc);
            exp_pc = exp_pc + 32'd4;
            @(negedge clock);
        end
    endtask

    task automatic fetch_at(fetch_pkg::addr_t target);
        redirect_to(target);
        wait_valid("waiting on a redirect target");
        check_inst(target);                 // First valid must be the target
        @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic cold_sequential_fetch();
        collect_stream(RESET_PC, COLD_COUNT);
    endtask

    task automatic hit_stream();
        fetch_pkg::addr_t exp_pc;
        exp_pc = RESET_PC;
        redirect_to(RESET_PC);
        for (int k = 0; k < COLD_COUNT; k++) begin
            expect_valid(1'b1);             // Lines already cached, no bubbles
            check_inst(exp_pc);
            exp_pc = exp_pc + 32'd4;
            @(negedge clock);
        end
    endtask

    task automatic redirect_during_miss();
        redirect_to(ABANDON_PC);
        repeat (3) begin
            expect_valid(1'b0);             // Load goes out and gets its tag
            @(negedge clock);
        end
        fetch_at(TARGET_PC);
    endtask

    task automatic dmem_priority_block();
        dmem_priority = 1'b1;
        redirect_to(PRIORITY_PC);
        repeat (PRIORITY_CYCLES) begin
            expect_valid(1'b0);
            @(negedge clock);
        end
        dmem_priority = 1'b0;
        collect_stream(PRIORITY_PC, RESUME_COUNT);
    endtask

    task automatic stall_hold();
        stall = 1'b1;
        redirect_to(STALL_PC);
        wait_valid("stalled on a miss");    // Miss completes under stall
        repeat (STALL_CYCLES) begin
            expect_valid(1'b1);
            check_inst(STALL_PC);
            @(negedge clock);
        end
        check_inst(STALL_PC);
        stall = 1'b0;
        @(negedge clock);
        expect_valid(1'b1);                 // Same line, hits at once
        check_inst(STALL_PC + 32'd4);
        @(negedge clock);
    endtask

    task automatic conflict_eviction();
        repeat (CONFLICT_ROUNDS) begin
            fetch_at(CONFLICT_A);
            fetch_at(CONFLICT_B);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("Watchdog expired before the tests finished");
    end

    initial begin
        reset         = 1'b1;
        reset_pc      = RESET_PC;
        stall         = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        dmem_priority = 1'b0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        lcg_state     = 32'h329562c0;

        apply_reset();
        preload_memory();
        apply_reset();                      // Clears the cache, memory keeps its lines

        cold_sequential_fetch();
        hit_stream();
        redirect_during_miss();
        dmem_priority_block();
        stall_hold();
        conflict_eviction();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/mem_bus_if.sv
rtl/icache.sv
rtl/tagged_memory.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
dv/fetch_tb.sv

//--- rtl/fetch_config.svh
/*
 * Instruction-fetch subsystem configuration
 * Address width, cache geometry, memory size and memory latency
 */

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Address and program-counter width
`define FETCH_XLEN 32

// Cache lines, any power of two
`define FETCH_CACHE_LINES 32

// Memory bytes, address bits 15:3 pick an 8-byte line
`define FETCH_MEM_BYTES 65536

// Cycles from an accepted load to its data beat
`define FETCH_MEM_LATENCY 8

`endif

//--- rtl/fetch_pkg.sv
/*
 * Fetch package
 * Address, line, instruction and tag types plus the memory bus command
 */

`include "fetch_config.svh"

package fetch_pkg;

    // Derived widths
    localparam int CACHE_INDEX_BITS = $clog2(`FETCH_CACHE_LINES);
    localparam int LINE_ADDR_BITS   = $clog2(`FETCH_MEM_BYTES) - 3; // Line number bits, 13

    typedef logic [`FETCH_XLEN-1:0] addr_t;   // Byte address
    typedef logic [63:0]            line_t;   // Two instructions
    typedef logic [31:0]            inst_t;   // One instruction
    typedef logic [3:0]             mem_tag_t; // Memory transaction tag, 0 = none

    // Cache set index and the line-address bits stored above it
    typedef logic [CACHE_INDEX_BITS-1:0]                cache_index_t;
    typedef logic [LINE_ADDR_BITS-CACHE_INDEX_BITS-1:0] cache_tag_t;

    // Memory bus command
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

endpackage

//--- rtl/fetch_top.sv
/*
 * Instruction-fetch top level
 * Fetch unit, instruction cache and tagged memory on one bus
 */

module fetch_top (
    input  logic             clock,
    input  logic             reset,
    input  fetch_pkg::addr_t reset_pc,
    input  logic             stall,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             dmem_priority,
    input  logic             load_en,
    input  fetch_pkg::addr_t load_addr,
    input  fetch_pkg::line_t load_data,
    output fetch_pkg::inst_t inst,
    output fetch_pkg::addr_t inst_pc,
    output logic             inst_valid
);

    fetch_pkg::addr_t fetch_addr; // Fetch unit to cache
    fetch_pkg::line_t line;
    logic             line_valid;

    mem_bus_if bus ();

    fetch_unit fetch_unit_inst (
        .clock       (clock),
        .reset       (reset),
        .reset_pc    (reset_pc),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .line        (line),
        .line_valid  (line_valid),
        .fetch_addr  (fetch_addr),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_valid  (inst_valid)
    );

    icache icache_inst (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .line       (line),
        .line_valid (line_valid),
        .bus        (bus.cache)
    );

    tagged_memory tagged_memory_inst (
        .clock         (clock),
        .reset         (reset),
        .dmem_priority (dmem_priority),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .bus           (bus.memory)
    );

endmodule

//--- rtl/fetch_unit.sv
/*
 * Fetch unit
 * Program counter with redirect and stall, picks the instruction half of the line
 */

module fetch_unit (
    input  logic             clock,
    input  logic             reset,
    input  fetch_pkg::addr_t reset_pc,
    input  logic             stall,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  fetch_pkg::line_t line,
    input  logic             line_valid,
    output fetch_pkg::addr_t fetch_addr,
    output fetch_pkg::inst_t inst,
    output fetch_pkg::addr_t inst_pc,
    output logic             inst_valid
);

    fetch_pkg::addr_t pc;

    // Redirect beats stall, advance only on a delivered instruction
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (line_valid && !stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign fetch_addr = pc;

    // Bit 2 picks the upper word
    assign inst       = pc[2] ? line[63:32] : line[31:0];
    assign inst_pc    = pc;
    assign inst_valid = line_valid;

    // Word alignment holds at every edge
    pc_aligned_a : assert property (@(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

//--- rtl/icache.sv
/*
 * Blocking direct-mapped instruction cache
 * Hits return the line in the same cycle; misses load from the tagged memory
 * and a pending miss is dropped when the fetch address moves
 */

`include "fetch_config.svh"

module icache (
    input  logic             clock,
    input  logic             reset,
    input  fetch_pkg::addr_t fetch_addr,
    output fetch_pkg::line_t line,
    output logic             line_valid,
    mem_bus_if.cache         bus
);

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    fetch_pkg::line_t        data_array [`FETCH_CACHE_LINES];
    fetch_pkg::cache_tag_t   tag_array  [`FETCH_CACHE_LINES];
    logic [`FETCH_CACHE_LINES-1:0] valid_bits;

    // Current and previous address split, cache tag not memory tag
    fetch_pkg::cache_tag_t   current_tag, last_tag;
    fetch_pkg::cache_index_t current_index, last_index;

    assign {current_tag, current_index} = fetch_addr[fetch_pkg::LINE_ADDR_BITS+2:3];

    // Lookup
    assign line       = data_array[current_index];
    assign line_valid = valid_bits[current_index] && (tag_array[current_index] == current_tag);

    ////////////////////////////////////////////////////////////////////////////
    // Miss tracking
    ////////////////////////////////////////////////////////////////////////////

    fetch_pkg::mem_tag_t current_mem_tag;  // Memory tag being waited on
    logic                miss_outstanding; // Still asking for a response tag
    logic                addr_fresh;       // First cycle out of reset
    logic                changed_addr;
    logic                got_mem_data;
    logic                fill;
    logic                update_mem_tag;
    logic                unanswered_miss;

    // Out of reset the address counts as new, so a cold miss gets issued
    assign changed_addr = addr_fresh || (current_index != last_index) ||
                          (current_tag != last_tag);

    assign got_mem_data = (current_mem_tag != '0) && (bus.data_tag == current_mem_tag);
    assign fill         = got_mem_data && !changed_addr; // Beat for an address still wanted

    // Reload the memory tag on a move, while asking, and once the beat lands
    // Response is 0 whenever no load is on the bus
    assign update_mem_tag = changed_addr || miss_outstanding || got_mem_data;

    // New miss, or an old one the memory refused this cycle
    assign unanswered_miss = changed_addr ? !line_valid
                                          : miss_outstanding && (bus.response == '0);

    // Request repeats until tagged or abandoned
    assign bus.command = (miss_outstanding && !changed_addr) ? fetch_pkg::BUS_LOAD
                                                              : fetch_pkg::BUS_NONE;
    assign bus.addr    = {fetch_addr[`FETCH_XLEN-1:3], 3'b000};

    always_ff @(posedge clock) begin
        if (reset) begin
            addr_fresh       <= 1'b1;
            miss_outstanding <= 1'b0;
            current_mem_tag  <= '0;
            valid_bits       <= '0;
        end else begin
            addr_fresh       <= 1'b0;
            miss_outstanding <= unanswered_miss;
            if (update_mem_tag) begin
                current_mem_tag <= bus.response;
            end
            if (fill) begin
                valid_bits[current_index] <= 1'b1;
            end
        end
    end

    // Line payload and address history
    always_ff @(posedge clock) begin
        last_index <= current_index;
        last_tag   <= current_tag;
        if (fill) begin
            data_array[current_index] <= bus.data;
            tag_array[current_index]  <= current_tag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Fetch side never writes
    no_store_a : assert property (@(posedge clock) disable iff (reset)
        bus.command != fetch_pkg::BUS_STORE);

    // Fills only take tagged beats from memory
    fill_tagged_a : assert property (@(posedge clock) disable iff (reset)
        fill |-> (bus.data_tag != '0));

    // A filled line hits next cycle if fetch stays put
    fill_hits_a : assert property (@(posedge clock) disable iff (reset)
        fill |=> (fetch_addr != $past(fetch_addr)) || line_valid);

endmodule

//--- rtl/mem_bus_if.sv
/*
 * Cache-to-memory bus
 * Command and address out, response tag, data and data tag back
 */

interface mem_bus_if;

    fetch_pkg::bus_command_t command;  // From the cache
    fetch_pkg::addr_t        addr;     // Line-aligned address
    fetch_pkg::mem_tag_t     response; // Tag granted this cycle, 0 = refused
    fetch_pkg::line_t        data;     // Returned line
    fetch_pkg::mem_tag_t     data_tag; // Tag of the beat, 0 when idle

    modport cache (
        output command, addr,
        input  response, data, data_tag
    );

    modport memory (
        input  command, addr,
        output response, data, data_tag
    );

endinterface

//--- rtl/tagged_memory.sv
/*
 * Tagged multi-cycle memory model
 * Grants rotating nonzero tags, returns each line a fixed latency later,
 * and refuses fetch loads while the data side holds the bus
 */

`include "fetch_config.svh"

module tagged_memory (
    input  logic             clock,
    input  logic             reset,
    input  logic             dmem_priority,
    input  logic             load_en,
    input  fetch_pkg::addr_t load_addr,
    input  fetch_pkg::line_t load_data,
    mem_bus_if.memory        bus
);

    localparam int LATENCY    = `FETCH_MEM_LATENCY;
    localparam int LINE_COUNT = `FETCH_MEM_BYTES / 8;
    localparam int LA_BITS    = fetch_pkg::LINE_ADDR_BITS;

    fetch_pkg::line_t    mem_lines [LINE_COUNT];
    fetch_pkg::mem_tag_t pipe_tag  [LATENCY];     // Tag per stage, 0 = empty
    logic [LA_BITS-1:0]  pipe_line_addr [LATENCY];
    fetch_pkg::mem_tag_t next_tag;                // Next tag to hand out
    logic                tag_busy;
    logic                accept;

    // Next tag still somewhere in flight
    always_comb begin
        tag_busy = 1'b0;
        for (int i = 0; i < LATENCY; i++) begin
            if (pipe_tag[i] == next_tag) begin
                tag_busy = 1'b1;
            end
        end
    end

    assign accept = (bus.command == fetch_pkg::BUS_LOAD) && !dmem_priority && !tag_busy;

    // Same-cycle answer, beat from the last stage
    assign bus.response = accept ? next_tag : '0;
    assign bus.data_tag = pipe_tag[LATENCY-1];
    assign bus.data     = mem_lines[pipe_line_addr[LATENCY-1]];

    // Preload port, contents survive reset
    always_ff @(posedge clock) begin
        if (load_en) begin
            mem_lines[load_addr[LA_BITS+2:3]] <= load_data;
        end
    end

    // Tag pipeline and rotation 1..15
    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= accept ? next_tag : '0;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
            if (accept) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
        end
    end

    // Line addresses ride alongside their tags
    always_ff @(posedge clock) begin
        pipe_line_addr[0] <= bus.addr[LA_BITS+2:3];
        for (int i = 1; i < LATENCY; i++) begin
            pipe_line_addr[i] <= pipe_line_addr[i-1];
        end
    end

    // In-flight tags stay unique across the whole pipeline
    for (genvar i = 0; i < LATENCY; i++) begin : g_tag_i
        for (genvar j = i + 1; j < LATENCY; j++) begin : g_tag_j
            unique_tag_a : assert property (@(posedge clock) disable iff (reset)
                (pipe_tag[i] == '0) || (pipe_tag[i] != pipe_tag[j]));
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the fetch testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module fetch_tb \
    -Mdir obj_dir \
    -o fetch_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/fetch_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0
